//--- rv_core.f
+incdir+common
common/rv_pkg.sv
hdl/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/alu.sv
execute/execute_stage.sv
hdl/writeback_stage.sv
hdl/rv_core.sv
sim/tb_mem_model.sv
sim/tb_rv_core.sv

//--- sim/tb_rv_core.sv
`default_nettype none

`include "rv_defines.svh"

module tb_rv_core;

    timeunit 1ns;
    timeprecision 100ps;

    localparam rv_pkg::word_t POISON_ADDR = 32'h0000_03fc;
    localparam int TIMEOUT_CYCLES = 2000;

    logic          clk;
    logic          rst_n;
    rv_pkg::word_t imem_addr;
    rv_pkg::word_t imem_rdata;
    rv_pkg::word_t dmem_addr;
    rv_pkg::word_t dmem_wdata;
    logic          dmem_we;
    rv_pkg::word_t dmem_rdata;

    rv_pkg::word_t prog [0:255];
    int            prog_len;
    rv_pkg::word_t exp_addr [0:63];
    rv_pkg::word_t exp_data [0:63];
    int            exp_count;
    rv_pkg::word_t next_slot;
    rv_pkg::word_t lcg_state;
    int            store_idx;
    int            hit_count;
    int            error_count;

    rv_core i_rv_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    tb_mem_model i_mem (.*);

    always #2 clk = ~clk;

    ////////////////////////////////////////
    // Encoders and reference arithmetic
    ////////////////////////////////////////

    function automatic rv_pkg::word_t next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic rv_pkg::word_t r_type(input logic f7b, input int rs2, rs1,
                                             input logic [2:0] f3, input int rd);
        return {1'b0, f7b, 5'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], rv_pkg::OP};
    endfunction

    function automatic rv_pkg::word_t i_type(input logic [11:0] imm, input int rs1, f3, rd,
                                             input logic [6:0] opc);
        return {imm, rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    // SW only
    function automatic rv_pkg::word_t s_type(input logic [11:0] imm, input int rs2, rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], rv_pkg::STORE};
    endfunction

    function automatic rv_pkg::word_t b_type(input logic [12:0] off, input int rs2, rs1,
                                             input logic [2:0] f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11],
                rv_pkg::BRANCH};
    endfunction

    function automatic rv_pkg::word_t u_type(input logic [19:0] imm, input int rd);
        return {imm, rd[4:0], rv_pkg::LUI};
    endfunction

    function automatic rv_pkg::word_t j_type(input logic [20:0] off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], rv_pkg::JAL};
    endfunction

    function automatic rv_pkg::word_t alu_ref(input logic f7b, input logic [2:0] f3,
                                              input rv_pkg::word_t a, input rv_pkg::word_t b);
        case (f3)
            3'd0: return f7b ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (f7b) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input rv_pkg::word_t a,
                                        input rv_pkg::word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    ////////////////////////////////////////
    // Program construction
    ////////////////////////////////////////

    task automatic emit(input rv_pkg::word_t word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    // LUI then ADDI, upper part rounded for the sign of the low 12 bits
    task automatic load_const(input int rd, input rv_pkg::word_t value);
        rv_pkg::word_t upper;
        upper = value + 32'h800;
        emit(u_type(upper[31:12], rd));
        emit(i_type(value[11:0], rd, 0, rd, rv_pkg::OP_IMM));
    endtask

    task automatic expect_store(input int rs2, input rv_pkg::word_t data);
        emit(s_type(next_slot[11:0], rs2, 0));
        exp_addr[exp_count] = next_slot;
        exp_data[exp_count] = data;
        exp_count++;
        next_slot = next_slot + 4;
    endtask

    task automatic store_poison(input int rs2);
        emit(s_type(POISON_ADDR[11:0], rs2, 0));
    endtask

    task automatic build_program();
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t r;
        logic [2:0]    f3;
        int            k;
        int            cond;
        int            p;
        int            off;

        // Ten register-register ops, each feeding the next
        for (k = 0; k < 10; k++) begin
            a  = next_random();
            b  = next_random();
            f3 = (k < 8) ? k[2:0] : ((k == 8) ? 3'd0 : 3'd5);
            load_const(1, a);
            load_const(2, b);
            emit(r_type(k >= 8, 2, 1, f3, 3));
            expect_store(3, alu_ref(k >= 8, f3, a, b));
        end
        a = next_random();
        emit(u_type(a[31:12], 3));
        expect_store(3, {a[31:12], 12'h000});

        // x0 keeps reading zero
        load_const(0, next_random());
        expect_store(0, 32'h0);

        // Load then use in the very next instruction
        a = next_random();
        b = next_random();
        load_const(2, b);
        load_const(1, a);
        expect_store(1, a);
        r = next_slot - 4;
        emit(i_type(r[11:0], 0, 2, 4, rv_pkg::LOAD));
        emit(r_type(1'b0, 2, 4, 3'd0, 5));
        expect_store(5, a + b);

        // Each condition once with (a, b) and once mirrored
        for (k = 0; k < 12; k++) begin
            cond = k / 2;
            f3   = (cond < 2) ? cond[2:0] : cond[2:0] + 3'd2;
            if (k % 2 == 0) begin
                a = next_random();
                b = next_random();
            end else if (f3[2]) begin
                r = a;
                a = b;
                b = r;
            end else begin
                b = a;
            end
            load_const(1, a);
            load_const(2, b);
            emit(b_type(13'd12, 2, 1, f3));
            if (branch_ref(f3, a, b)) begin
                store_poison(1);
                store_poison(2);
            end else begin
                expect_store(1, a);
                expect_store(2, b);
            end
        end

        // JALR with an odd sum lands on p + 12
        r   = next_random();
        off = r[4:0];
        p   = prog_len * 4 + 8;
        load_const(7, p + 13 - off);
        emit(i_type(off[11:0], 7, 0, 8, rv_pkg::JALR));
        store_poison(8);
        store_poison(8);
        expect_store(8, p + 4);

        p = prog_len * 4;
        emit(j_type(21'd12, 6));
        store_poison(6);
        store_poison(6);
        expect_store(6, p + 4);

        // Park in a tight loop
        emit(j_type(21'd0, 0));
    endtask

    ////////////////////////////////////////
    // Store checks
    ////////////////////////////////////////

    function automatic logic store_matches(input int idx, input rv_pkg::word_t addr,
                                           input rv_pkg::word_t data);
        return (idx < exp_count) && (exp_addr[idx] == addr) && (exp_data[idx] == data);
    endfunction

    reset_quiet: assert property (@(negedge clk) !rst_n |-> !dmem_we)
        else begin
            error_count++;
            $display("Store enable raised while reset was held");
        end

    no_poison: assert property (@(negedge clk) disable iff (!rst_n)
                               dmem_we |-> dmem_addr != POISON_ADDR)
        else begin
            error_count++;
            $display("Store from a killed instruction reached memory");
        end

    store_in_order: assert property (@(negedge clk) disable iff (!rst_n)
                                    dmem_we |-> store_matches(store_idx, dmem_addr, dmem_wdata))
        else begin
            error_count++;
            if ($sampled(store_idx) >= exp_count) begin
                $display("Store seen after the last expected store, address %h", dmem_addr);
            end else begin
                $display("ERROR dmem_addr/dmem_wdata: got %h/%h expected %h/%h",
                         dmem_addr, dmem_wdata, exp_addr[$sampled(store_idx)],
                         exp_data[$sampled(store_idx)]);
            end
        end

    always @(negedge clk) begin
        if (rst_n && dmem_we) begin
            if (store_matches(store_idx, dmem_addr, dmem_wdata)) begin
                hit_count++;
            end
            store_idx <= store_idx + 1;
        end
    end

    initial begin
        int cycles;

        clk         = 1'b0;
        rst_n       = 1'b0;
        lcg_state   = 32'he56c_741d;
        prog_len    = 0;
        exp_count   = 0;
        next_slot   = '0;
        store_idx   = 0;
        hit_count   = 0;
        error_count = 0;
        build_program();

        @(posedge clk);
        for (int i = 0; i < prog_len; i++) begin
            i_mem.write_rom_word(i, prog[i]);
        end
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        @(negedge clk);
        assert (imem_addr == `RV_RESET_PC) hit_count++;
        else begin
            error_count++;
            $display("ERROR imem_addr: got %h expected %h", imem_addr, `RV_RESET_PC);
        end
        assert (!dmem_we) hit_count++;
        else begin
            error_count++;
            $display("ERROR dmem_we: got %h expected 0", dmem_we);
        end

        cycles = 0;
        while (store_idx < exp_count && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (store_idx < exp_count) begin
            error_count++;
            $display("Timed out with %0d of %0d stores seen", store_idx, exp_count);
        end
        // A few more cycles so stray stores still show up
        repeat (4) @(negedge clk);

        $display("Store checks: %0d errors, %0d hits", error_count, hit_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_mem_model.sv
`default_nettype none

module tb_mem_model (
    input  logic          clk,
    input  rv_pkg::word_t imem_addr,
    output rv_pkg::word_t imem_rdata,
    input  rv_pkg::word_t dmem_addr,
    input  rv_pkg::word_t dmem_wdata,
    input  logic          dmem_we,
    output rv_pkg::word_t dmem_rdata
);

    timeunit 1ns;
    timeprecision 100ps;

    // Two 1 KB arrays indexed by address bits 9:2
    rv_pkg::word_t rom [0:255];
    rv_pkg::word_t ram [0:255];

    initial begin
        imem_rdata = '0;
        dmem_rdata = '0;
        for (int i = 0; i < 256; i++) begin
            // Unused ROM words are NOPs that carry their own index
            rom[i] = 32'h0000_0013 | rv_pkg::word_t'(i << 20);
            ram[i] = rv_pkg::word_t'(i << 2) ^ 32'h5a5a_0000;
        end
    end

    task automatic write_rom_word(input int index, input rv_pkg::word_t word);
        rom[index] = word;
    endtask

    // Both ports return read data 1 ns after the sampling edge
    always @(posedge clk) begin
        imem_rdata <= #1 rom[imem_addr[9:2]];
        dmem_rdata <= #1 ram[dmem_addr[9:2]];
        if (dmem_we) begin
            ram[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

endmodule

`default_nettype wire

//--- hdl/rv_core.sv
`default_nettype none

`include "rv_defines.svh"

module rv_core (
    input  logic          clk,
    input  logic          rst_n,
    output rv_pkg::word_t imem_addr,
    input  rv_pkg::word_t imem_rdata,
    output rv_pkg::word_t dmem_addr,
    output rv_pkg::word_t dmem_wdata,
    output logic          dmem_we,
    input  rv_pkg::word_t dmem_rdata
);

    ////////////////////////////////////////
    // Stage to stage wires
    ////////////////////////////////////////

    rv_pkg::word_t    pc_id;
    logic             id_valid;
    logic             jal_taken;
    rv_pkg::word_t    jal_target;
    logic             br_taken;
    rv_pkg::word_t    br_target;

    logic             x_valid;
    rv_pkg::word_t    x_pc;
    rv_pkg::reg_idx_t x_rs1;
    rv_pkg::reg_idx_t x_rs2;
    rv_pkg::reg_idx_t x_rd;
    rv_pkg::word_t    x_rs1_data;
    rv_pkg::word_t    x_rs2_data;
    rv_pkg::word_t    x_imm;
    rv_pkg::alu_op_t  x_alu_op;
    logic             x_a_pc;
    logic             x_b_imm;
    rv_pkg::br_cond_t x_br_cond;
    logic             x_is_branch;
    logic             x_is_jalr;
    logic             x_is_load;
    logic             x_is_store;
    logic             x_reg_we;
    rv_pkg::wb_sel_t  x_wb_sel;

    logic             ex_valid_we;
    rv_pkg::reg_idx_t ex_rd;
    rv_pkg::word_t    ex_result;
    rv_pkg::word_t    ex_link;
    rv_pkg::wb_sel_t  ex_wb_sel;

    logic             wb_we;
    rv_pkg::reg_idx_t wb_rd;
    rv_pkg::word_t    wb_data;

    fetch_stage i_fetch_stage (.*);

    // Decode takes the ROM word directly, execute redirects flush it
    decode_stage i_decode_stage (
        .instr (imem_rdata),
        .flush (br_taken),
        .*
    );

    execute_stage i_execute_stage (.*);

    writeback_stage i_writeback_stage (.*);

endmodule

`default_nettype wire

//--- hdl/writeback_stage.sv
`default_nettype none

`include "rv_defines.svh"

module writeback_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             ex_valid_we,
    input  rv_pkg::reg_idx_t ex_rd,
    input  rv_pkg::word_t    ex_result,
    input  rv_pkg::word_t    ex_link,
    input  rv_pkg::wb_sel_t  ex_wb_sel,
    input  rv_pkg::word_t    dmem_rdata,
    output logic             wb_we,
    output rv_pkg::reg_idx_t wb_rd,
    output rv_pkg::word_t    wb_data
);

    rv_pkg::word_t   result_q;
    rv_pkg::word_t   link_q;
    rv_pkg::wb_sel_t sel_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= ex_valid_we;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd    <= ex_rd;
        result_q <= ex_result;
        link_q   <= ex_link;
        sel_q    <= ex_wb_sel;
    end

    // Load data arrives this cycle from the synchronous RAM
    always_comb begin
        case (sel_q)
            rv_pkg::MEM:  wb_data = dmem_rdata;
            rv_pkg::LINK: wb_data = link_q;
            default:      wb_data = result_q;
        endcase
    end

endmodule

`default_nettype wire

//--- execute/execute_stage.sv
`default_nettype none

`include "rv_defines.svh"

module execute_stage (
    input  logic             x_valid,
    input  rv_pkg::word_t    x_pc,
    input  rv_pkg::reg_idx_t x_rs1,
    input  rv_pkg::reg_idx_t x_rs2,
    input  rv_pkg::reg_idx_t x_rd,
    input  rv_pkg::word_t    x_rs1_data,
    input  rv_pkg::word_t    x_rs2_data,
    input  rv_pkg::word_t    x_imm,
    input  rv_pkg::alu_op_t  x_alu_op,
    input  logic             x_a_pc,
    input  logic             x_b_imm,
    input  rv_pkg::br_cond_t x_br_cond,
    input  logic             x_is_branch,
    input  logic             x_is_jalr,
    input  logic             x_is_load,
    input  logic             x_is_store,
    input  logic             x_reg_we,
    input  rv_pkg::wb_sel_t  x_wb_sel,
    input  logic             wb_we,
    input  rv_pkg::reg_idx_t wb_rd,
    input  rv_pkg::word_t    wb_data,
    output logic             br_taken,
    output rv_pkg::word_t    br_target,
    output rv_pkg::word_t    dmem_addr,
    output rv_pkg::word_t    dmem_wdata,
    output logic             dmem_we,
    output logic             ex_valid_we,
    output rv_pkg::reg_idx_t ex_rd,
    output rv_pkg::word_t    ex_result,
    output rv_pkg::word_t    ex_link,
    output rv_pkg::wb_sel_t  ex_wb_sel
);

    rv_pkg::word_t rs1_val;
    rv_pkg::word_t rs2_val;
    rv_pkg::word_t alu_a;
    rv_pkg::word_t alu_b;
    rv_pkg::word_t alu_result;
    logic          cond_met;

    // Writeback forwarding, covers load-use as well
    assign rs1_val = (wb_we && (wb_rd == x_rs1)) ? wb_data : x_rs1_data;
    assign rs2_val = (wb_we && (wb_rd == x_rs2)) ? wb_data : x_rs2_data;

    assign alu_a = x_a_pc  ? x_pc  : rs1_val;
    assign alu_b = x_b_imm ? x_imm : rs2_val;

    alu i_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (x_alu_op),
        .result (alu_result)
    );

    always_comb begin
        case (x_br_cond)
            rv_pkg::EQ:  cond_met = (rs1_val == rs2_val);
            rv_pkg::NE:  cond_met = (rs1_val != rs2_val);
            rv_pkg::LT:  cond_met = ($signed(rs1_val) < $signed(rs2_val));
            rv_pkg::GE:  cond_met = ($signed(rs1_val) >= $signed(rs2_val));
            rv_pkg::LTU: cond_met = (rs1_val < rs2_val);
            rv_pkg::GEU: cond_met = (rs1_val >= rs2_val);
            default:     cond_met = 1'b0;
        endcase
    end

    // Branch target is pc + imm from the ALU, JALR drops bit 0
    assign br_taken  = x_valid && ((x_is_branch && cond_met) || x_is_jalr);
    assign br_target = x_is_jalr ? {alu_result[`RV_XLEN-1:1], 1'b0} : alu_result;

    assign dmem_addr  = alu_result;
    assign dmem_wdata = rs2_val;
    assign dmem_we    = x_valid && x_is_store;

    assign ex_valid_we = x_valid && x_reg_we;
    assign ex_rd       = x_rd;
    assign ex_result   = alu_result;
    assign ex_link     = x_pc + rv_pkg::word_t'(4);
    // Loads take their result from the data port
    assign ex_wb_sel   = x_is_load ? rv_pkg::MEM : x_wb_sel;

endmodule

`default_nettype wire

//--- execute/alu.sv
`default_nettype none

`include "rv_defines.svh"

module alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::alu_op_t op,
    output rv_pkg::word_t   result
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            rv_pkg::ADD:    result = a + b;
            rv_pkg::SUB:    result = a - b;
            rv_pkg::SLL:    result = a << shamt;
            rv_pkg::SLT:    result = {{(`RV_XLEN-1){1'b0}}, lt_s};
            rv_pkg::SLTU:   result = {{(`RV_XLEN-1){1'b0}}, lt_u};
            rv_pkg::XOR:    result = a ^ b;
            rv_pkg::SRL:    result = a >> shamt;
            rv_pkg::SRA:    result = rv_pkg::word_t'($signed(a) >>> shamt);
            rv_pkg::OR:     result = a | b;
            rv_pkg::AND:    result = a & b;
            // LUI immediate goes straight through
            rv_pkg::PASS_B: result = b;
            default:        result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- decode/decode_stage.sv
`default_nettype none

`include "rv_defines.svh"

module decode_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  rv_pkg::word_t      instr,
    input  rv_pkg::word_t      pc_id,
    input  logic               id_valid,
    input  logic               flush,
    input  logic               wb_we,
    input  rv_pkg::reg_idx_t   wb_rd,
    input  rv_pkg::word_t      wb_data,
    output logic               jal_taken,
    output rv_pkg::word_t      jal_target,
    output logic               x_valid,
    output rv_pkg::word_t      x_pc,
    output rv_pkg::reg_idx_t   x_rs1,
    output rv_pkg::reg_idx_t   x_rs2,
    output rv_pkg::reg_idx_t   x_rd,
    output rv_pkg::word_t      x_rs1_data,
    output rv_pkg::word_t      x_rs2_data,
    output rv_pkg::word_t      x_imm,
    output rv_pkg::alu_op_t    x_alu_op,
    output logic               x_a_pc,
    output logic               x_b_imm,
    output rv_pkg::br_cond_t   x_br_cond,
    output logic               x_is_branch,
    output logic               x_is_jalr,
    output logic               x_is_load,
    output logic               x_is_store,
    output logic               x_reg_we,
    output rv_pkg::wb_sel_t    x_wb_sel
);

    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rd;
    logic [2:0]       funct3;
    rv_pkg::word_t    rs1_data;
    rv_pkg::word_t    rs2_data;
    rv_pkg::word_t    imm_i;
    rv_pkg::word_t    imm_s;
    rv_pkg::word_t    imm_b;
    rv_pkg::word_t    imm_u;
    rv_pkg::word_t    imm_j;
    rv_pkg::word_t    imm;
    rv_pkg::alu_op_t  alu_op;
    logic             a_pc;
    logic             b_imm;
    logic             is_branch;
    logic             is_jal;
    logic             is_jalr;
    logic             is_load;
    logic             is_store;
    logic             reg_we;
    rv_pkg::wb_sel_t  wb_sel;
    logic             live;

    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];

    reg_file i_reg_file (
        .clk      (clk),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (wb_rd),
        .we       (wb_we),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    ////////////////////////////////////////
    // Immediates
    ////////////////////////////////////////

    assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`RV_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{(`RV_XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    ////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////

    always_comb begin
        imm       = imm_i;
        alu_op    = rv_pkg::ADD;
        a_pc      = 1'b0;
        b_imm     = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        reg_we    = 1'b0;
        wb_sel    = rv_pkg::ALU;

        // Shared funct3 map for OP and OP_IMM, SUB only exists in OP
        case (funct3)
            3'b000:  alu_op = (instr[6:0] == rv_pkg::OP && instr[30]) ? rv_pkg::SUB
                                                                        : rv_pkg::ADD;
            3'b001:  alu_op = rv_pkg::SLL;
            3'b010:  alu_op = rv_pkg::SLT;
            3'b011:  alu_op = rv_pkg::SLTU;
            3'b100:  alu_op = rv_pkg::XOR;
            3'b101:  alu_op = instr[30] ? rv_pkg::SRA : rv_pkg::SRL;
            3'b110:  alu_op = rv_pkg::OR;
            default: alu_op = rv_pkg::AND;
        endcase

        case (instr[6:0])
            rv_pkg::OP: begin
                reg_we = 1'b1;
            end
            rv_pkg::OP_IMM: begin
                b_imm  = 1'b1;
                reg_we = 1'b1;
            end
            rv_pkg::LUI: begin
                imm    = imm_u;
                alu_op = rv_pkg::PASS_B;
                b_imm  = 1'b1;
                reg_we = 1'b1;
            end
            rv_pkg::LOAD: begin
                alu_op  = rv_pkg::ADD;
                b_imm   = 1'b1;
                is_load = 1'b1;
                reg_we  = 1'b1;
            end
            rv_pkg::STORE: begin
                imm      = imm_s;
                alu_op   = rv_pkg::ADD;
                b_imm    = 1'b1;
                is_store = 1'b1;
            end
            rv_pkg::BRANCH: begin
                // ALU forms the target, the comparator decides
                imm       = imm_b;
                alu_op    = rv_pkg::ADD;
                a_pc      = 1'b1;
                b_imm     = 1'b1;
                is_branch = 1'b1;
            end
            rv_pkg::JAL: begin
                imm    = imm_j;
                is_jal = 1'b1;
                reg_we = 1'b1;
                wb_sel = rv_pkg::LINK;
            end
            rv_pkg::JALR: begin
                alu_op  = rv_pkg::ADD;
                b_imm   = 1'b1;
                is_jalr = 1'b1;
                reg_we  = 1'b1;
                wb_sel  = rv_pkg::LINK;
            end
            default: begin
                // Unsupported opcodes retire as bubbles
                reg_we = 1'b0;
            end
        endcase
    end

    assign live       = id_valid && !flush;
    assign jal_taken  = live && is_jal;
    assign jal_target = pc_id + imm_j;

    ////////////////////////////////////////
    // Decode to execute register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_valid <= 1'b0;
        end else begin
            x_valid <= live;
        end
    end

    always_ff @(posedge clk) begin
        x_pc        <= pc_id;
        x_rs1       <= rs1;
        x_rs2       <= rs2;
        x_rd        <= rd;
        x_rs1_data  <= rs1_data;
        x_rs2_data  <= rs2_data;
        x_imm       <= imm;
        x_alu_op    <= alu_op;
        x_a_pc      <= a_pc;
        x_b_imm     <= b_imm;
        x_br_cond   <= rv_pkg::br_cond_t'(funct3);
        x_is_branch <= is_branch;
        x_is_jalr   <= is_jalr;
        x_is_load   <= is_load;
        x_is_store  <= is_store;
        // Writes to x0 are dropped here
        x_reg_we    <= reg_we && (rd != '0);
        x_wb_sel    <= wb_sel;
    end

endmodule

`default_nettype wire

//--- decode/reg_file.sv
`default_nettype none

`include "rv_defines.svh"

module reg_file (
    input  logic             clk,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::reg_idx_t rd,
    input  logic             we,
    input  rv_pkg::word_t    wdata,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data
);

    // x0 has no storage
    rv_pkg::word_t regs [1:`RV_REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (we && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

    // Same-cycle write is passed straight through to the readers
    assign rs1_data = (rs1 == '0)             ? '0 :
                      (we && (rd == rs1))     ? wdata :
                                                regs[rs1];
    assign rs2_data = (rs2 == '0)             ? '0 :
                      (we && (rd == rs2))     ? wdata :
                                                regs[rs2];

endmodule

`default_nettype wire

//--- hdl/fetch_stage.sv
`default_nettype none

`include "rv_defines.svh"

module fetch_stage (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          jal_taken,
    input  rv_pkg::word_t jal_target,
    input  logic          br_taken,
    input  rv_pkg::word_t br_target,
    output rv_pkg::word_t imem_addr,
    output rv_pkg::word_t pc_id,
    output logic          id_valid
);

    rv_pkg::word_t pc;
    rv_pkg::word_t next_pc;

    // Execute redirect wins, it holds the older instruction
    always_comb begin
        if (br_taken) begin
            next_pc = br_target;
        end else if (jal_taken) begin
            next_pc = jal_target;
        end else begin
            next_pc = pc + rv_pkg::word_t'(4);
        end
    end

    // Word returning next cycle is dead after reset or any redirect
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= `RV_RESET_PC;
            id_valid <= 1'b0;
        end else begin
            pc       <= next_pc;
            id_valid <= !(br_taken || jal_taken);
        end
    end

    // PC of the word now in flight from the ROM
    always_ff @(posedge clk) begin
        pc_id <= pc;
    end

    assign imem_addr = pc;

endmodule

`default_nettype wire

//--- common/rv_pkg.sv
`default_nettype none

`include "rv_defines.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [`RV_REG_AW-1:0] reg_idx_t;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_t;

    // Encoded as {funct7[5], funct3} where RV32I defines one
    typedef enum logic [3:0] {
        ADD    = 4'b0000,
        SUB    = 4'b1000,
        SLL    = 4'b0001,
        SLT    = 4'b0010,
        SLTU   = 4'b0011,
        XOR    = 4'b0100,
        SRL    = 4'b0101,
        SRA    = 4'b1101,
        OR     = 4'b0110,
        AND    = 4'b0111,
        PASS_B = 4'b1111
    } alu_op_t;

    // Branch funct3 codes
    typedef enum logic [2:0] {
        EQ  = 3'b000,
        NE  = 3'b001,
        LT  = 3'b100,
        GE  = 3'b101,
        LTU = 3'b110,
        GEU = 3'b111
    } br_cond_t;

    typedef enum logic [1:0] {
        ALU  = 2'b00,
        MEM  = 2'b01,
        LINK = 2'b10
    } wb_sel_t;

endpackage

`default_nettype wire

//--- common/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

////////////////////////////////////////
// Core widths
////////////////////////////////////////

// Data and address word
`define RV_XLEN 32

// Register index and register count
`define RV_REG_AW 5
`define RV_REG_COUNT 32

////////////////////////////////////////
// Reset state
////////////////////////////////////////

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif
